// ==== axi_pkg.sv ====
package axi_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    localparam int AXI_LEN_W  = 8;
    localparam int AXI_SIZE_W = 3;
    localparam int AXI_RESP_W = 2;

    localparam logic [AXI_ID_W-1:0]  ID_INST    = 4'd0;  // Instruction port
    localparam logic [AXI_ID_W-1:0]  ID_DATA    = 4'd1;  // Data port
    localparam logic [1:0]           BURST_INCR = 2'b01;
    localparam logic [AXI_LEN_W-1:0] LEN_SINGLE = 8'd0;  // One beat

    typedef struct packed {
        logic [AXI_ID_W-1:0]   arid;
        logic [AXI_ADDR_W-1:0] araddr;
        logic [AXI_LEN_W-1:0]  arlen;
        logic [AXI_SIZE_W-1:0] arsize;
        logic [1:0]            arburst;
        logic                  arvalid;
        logic                  rready;
        logic [AXI_ID_W-1:0]   awid;
        logic [AXI_ADDR_W-1:0] awaddr;
        logic [AXI_LEN_W-1:0]  awlen;
        logic [AXI_SIZE_W-1:0] awsize;
        logic [1:0]            awburst;
        logic                  awvalid;
        logic [AXI_DATA_W-1:0] wdata;
        logic [AXI_STRB_W-1:0] wstrb;
        logic                  wlast;
        logic                  wvalid;
        logic                  bready;
    } axi_req_t;

    typedef struct packed {
        logic                  arready;
        logic [AXI_ID_W-1:0]   rid;
        logic [AXI_DATA_W-1:0] rdata;
        logic [AXI_RESP_W-1:0] rresp;
        logic                  rlast;
        logic                  rvalid;
        logic                  awready;
        logic                  wready;
        logic [AXI_ID_W-1:0]   bid;
        logic [AXI_RESP_W-1:0] bresp;
        logic                  bvalid;
    } axi_resp_t;

endpackage

// ==== sram_pkg.sv ====
package sram_pkg;

    localparam int SRAM_ADDR_W       = 32;
    localparam int SRAM_DATA_W       = 32;
    localparam int RESET_HOLD_CYCLES = 128;
    localparam int RESET_CNT_W       = $clog2(RESET_HOLD_CYCLES + 1);

    // Same encoding as the AXI size code
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    typedef struct packed {
        logic                   req;
        logic [SRAM_ADDR_W-1:0] addr;
    } inst_req_t;

    typedef struct packed {
        logic                   req;
        logic                   wr;
        size_e                  size;
        logic [SRAM_ADDR_W-1:0] addr;
        logic [SRAM_DATA_W-1:0] wdata;  // Already placed in its byte lanes
    } data_req_t;

    typedef struct packed {
        logic                   addr_ok;
        logic                   data_ok;
        logic [SRAM_DATA_W-1:0] rdata;
    } sram_resp_t;

    typedef struct packed {
        logic [axi_pkg::AXI_ID_W-1:0] id;
        size_e                        size;
        logic [SRAM_ADDR_W-1:0]       addr;
        logic [SRAM_DATA_W-1:0]       wdata;
    } chan_cmd_t;

endpackage

// ==== reset_stretch.sv ====
`timescale 1ns/1ps

module reset_stretch (
    input  logic Clk,
    input  logic Myreset,
    output logic core_rst_o
);

    logic [sram_pkg::RESET_CNT_W-1:0] hold_cnt;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            hold_cnt   <= '0;
            core_rst_o <= 1'b1;
        end else if (core_rst_o) begin
            if (hold_cnt == sram_pkg::RESET_HOLD_CYCLES) begin
                core_rst_o <= 1'b0;  // Hold time elapsed
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== req_arbiter.sv ====
`timescale 1ns/1ps

module req_arbiter (
    input  logic                             Clk,
    input  logic                             Myreset,
    input  logic                             core_rst_i,
    input  sram_pkg::inst_req_t              inst_req_i,
    input  sram_pkg::data_req_t              data_req_i,
    output sram_pkg::sram_resp_t             inst_resp_o,
    output sram_pkg::sram_resp_t             data_resp_o,
    output sram_pkg::chan_cmd_t              cmd_o,
    output logic                             rd_start_o,
    output logic                             wr_start_o,
    input  logic                             rd_done_i,
    input  logic                             wr_done_i,
    input  logic [sram_pkg::SRAM_DATA_W-1:0] rd_data_i
);

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

    arb_state_e                       state_q;
    logic                             owner_data_q;  // Data port owns the channel
    logic                             inst_ok_q;
    logic                             data_ok_q;
    logic [sram_pkg::SRAM_DATA_W-1:0] rdata_q;
    sram_pkg::chan_cmd_t              cmd_q;
    logic                             can_accept;
    logic                             data_win;
    logic                             inst_win;

    assign can_accept = (state_q == ARB_IDLE) && !core_rst_i;
    assign data_win   = can_accept && data_req_i.req;
    assign inst_win   = can_accept && inst_req_i.req && !data_req_i.req;  // Data first

    always_ff @(posedge Clk) begin
        if (Myreset || core_rst_i) begin
            state_q      <= ARB_IDLE;
            owner_data_q <= 1'b0;
            rd_start_o   <= 1'b0;
            wr_start_o   <= 1'b0;
            inst_ok_q    <= 1'b0;
            data_ok_q    <= 1'b0;
        end else begin
            rd_start_o <= inst_win || (data_win && !data_req_i.wr);
            wr_start_o <= data_win && data_req_i.wr;
            inst_ok_q  <= 1'b0;
            data_ok_q  <= 1'b0;
            case (state_q)
                ARB_IDLE: begin
                    if (data_win || inst_win) begin
                        state_q      <= ARB_BUSY;
                        owner_data_q <= data_win;
                    end
                end
                ARB_BUSY: begin
                    if (rd_done_i || wr_done_i) begin
                        state_q   <= ARB_IDLE;
                        inst_ok_q <= !owner_data_q;
                        data_ok_q <= owner_data_q;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // Held until the next grant, so the channels read it directly
    always_ff @(posedge Clk) begin
        if (data_win) begin
            cmd_q.id    <= axi_pkg::ID_DATA;
            cmd_q.size  <= data_req_i.size;
            cmd_q.addr  <= data_req_i.addr;
            cmd_q.wdata <= data_req_i.wdata;
        end else if (inst_win) begin
            cmd_q.id    <= axi_pkg::ID_INST;
            cmd_q.size  <= sram_pkg::SIZE_WORD;
            cmd_q.addr  <= inst_req_i.addr;
            cmd_q.wdata <= '0;
        end
        if (rd_done_i) begin
            rdata_q <= rd_data_i;
        end
    end

    always_comb begin
        inst_resp_o.addr_ok = inst_win;
        inst_resp_o.data_ok = inst_ok_q;
        inst_resp_o.rdata   = rdata_q;
        data_resp_o.addr_ok = data_win;
        data_resp_o.data_ok = data_ok_q;
        data_resp_o.rdata   = rdata_q;
    end

    assign cmd_o = cmd_q;

endmodule

// ==== axi_read_ch.sv ====
`timescale 1ns/1ps

module axi_read_ch (
    input  logic                             Clk,
    input  logic                             Myreset,
    input  logic                             core_rst_i,
    input  sram_pkg::chan_cmd_t              cmd_i,
    input  logic                             start_i,
    output axi_pkg::axi_req_t                ar_o,
    input  axi_pkg::axi_resp_t               resp_i,
    output logic                             done_o,
    output logic [sram_pkg::SRAM_DATA_W-1:0] rdata_o
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e state_q;

    always_ff @(posedge Clk) begin
        if (Myreset || core_rst_i) begin
            state_q <= RD_IDLE;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                RD_IDLE: begin
                    if (start_i) begin
                        state_q <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (resp_i.arready) begin
                        state_q <= RD_DATA;  // Address taken
                    end
                end
                RD_DATA: begin
                    if (resp_i.rvalid) begin
                        state_q <= RD_IDLE;
                        done_o  <= 1'b1;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state_q == RD_DATA && resp_i.rvalid) begin
            rdata_o <= resp_i.rdata;
        end
    end

    // Only the AR fields and rready come from here
    always_comb begin
        ar_o         = '0;
        ar_o.arid    = cmd_i.id;
        ar_o.araddr  = cmd_i.addr;
        ar_o.arlen   = axi_pkg::LEN_SINGLE;
        ar_o.arsize  = {1'b0, cmd_i.size};
        ar_o.arburst = axi_pkg::BURST_INCR;
        ar_o.arvalid = (state_q == RD_ADDR);
        ar_o.rready  = (state_q == RD_DATA);
    end

endmodule

// ==== axi_write_ch.sv ====
`timescale 1ns/1ps

module axi_write_ch (
    input  logic                Clk,
    input  logic                Myreset,
    input  logic                core_rst_i,
    input  sram_pkg::chan_cmd_t cmd_i,
    input  logic                start_i,
    output axi_pkg::axi_req_t   aw_w_o,
    input  axi_pkg::axi_resp_t  resp_i,
    output logic                done_o
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_RESP
    } wr_state_e;

    wr_state_e                      state_q;
    logic                           aw_pend_q;
    logic                           w_pend_q;
    logic                           aw_left;
    logic                           w_left;
    logic [axi_pkg::AXI_STRB_W-1:0] strb_mask;

    // Still waiting after this cycle
    assign aw_left = aw_pend_q && !resp_i.awready;
    assign w_left  = w_pend_q && !resp_i.wready;

    always_ff @(posedge Clk) begin
        if (Myreset || core_rst_i) begin
            state_q   <= WR_IDLE;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                WR_IDLE: begin
                    if (start_i) begin
                        state_q   <= WR_SEND;
                        aw_pend_q <= 1'b1;
                        w_pend_q  <= 1'b1;
                    end
                end
                WR_SEND: begin
                    aw_pend_q <= aw_left;
                    w_pend_q  <= w_left;
                    if (!aw_left && !w_left) begin
                        state_q <= WR_RESP;  // Both AW and W accepted
                    end
                end
                WR_RESP: begin
                    if (resp_i.bvalid) begin
                        state_q <= WR_IDLE;
                        done_o  <= 1'b1;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    always_comb begin
        case (cmd_i.size)
            sram_pkg::SIZE_BYTE: strb_mask = 4'b0001;
            sram_pkg::SIZE_HALF: strb_mask = 4'b0011;
            default:             strb_mask = 4'b1111;
        endcase
    end

    // AW, W and bready only
    always_comb begin
        aw_w_o         = '0;
        aw_w_o.awid    = cmd_i.id;
        aw_w_o.awaddr  = cmd_i.addr;
        aw_w_o.awlen   = axi_pkg::LEN_SINGLE;
        aw_w_o.awsize  = {1'b0, cmd_i.size};
        aw_w_o.awburst = axi_pkg::BURST_INCR;
        aw_w_o.awvalid = aw_pend_q;
        aw_w_o.wdata   = cmd_i.wdata;
        aw_w_o.wstrb   = strb_mask << cmd_i.addr[1:0];  // Lanes from the low address bits
        aw_w_o.wlast   = 1'b1;
        aw_w_o.wvalid  = w_pend_q;
        aw_w_o.bready  = (state_q == WR_RESP);
    end

endmodule

// ==== sram_axi_bridge.sv ====
`timescale 1ns/1ps

module sram_axi_bridge (
    input  logic                 Clk,
    input  logic                 Myreset,
    input  sram_pkg::inst_req_t  inst_req_i,
    input  sram_pkg::data_req_t  data_req_i,
    output sram_pkg::sram_resp_t inst_resp_o,
    output sram_pkg::sram_resp_t data_resp_o,
    output axi_pkg::axi_req_t    axi_req_o,
    input  axi_pkg::axi_resp_t   axi_resp_i
);

    logic                             core_rst;
    sram_pkg::chan_cmd_t              cmd;
    logic                             rd_start;
    logic                             wr_start;
    logic                             rd_done;
    logic                             wr_done;
    logic [sram_pkg::SRAM_DATA_W-1:0] rd_data;
    axi_pkg::axi_req_t                rd_req;
    axi_pkg::axi_req_t                wr_req;

    reset_stretch u_reset_stretch (
        .Clk        (Clk),
        .Myreset    (Myreset),
        .core_rst_o (core_rst)
    );

    req_arbiter u_req_arbiter (
        .Clk         (Clk),
        .Myreset     (Myreset),
        .core_rst_i  (core_rst),
        .inst_req_i  (inst_req_i),
        .data_req_i  (data_req_i),
        .inst_resp_o (inst_resp_o),
        .data_resp_o (data_resp_o),
        .cmd_o       (cmd),
        .rd_start_o  (rd_start),
        .wr_start_o  (wr_start),
        .rd_done_i   (rd_done),
        .wr_done_i   (wr_done),
        .rd_data_i   (rd_data)
    );

    axi_read_ch u_axi_read_ch (
        .Clk        (Clk),
        .Myreset    (Myreset),
        .core_rst_i (core_rst),
        .cmd_i      (cmd),
        .start_i    (rd_start),
        .ar_o       (rd_req),
        .resp_i     (axi_resp_i),
        .done_o     (rd_done),
        .rdata_o    (rd_data)
    );

    axi_write_ch u_axi_write_ch (
        .Clk        (Clk),
        .Myreset    (Myreset),
        .core_rst_i (core_rst),
        .cmd_i      (cmd),
        .start_i    (wr_start),
        .aw_w_o     (wr_req),
        .resp_i     (axi_resp_i),
        .done_o     (wr_done)
    );

    // Write side supplies AW, W and B; read side overrides AR and R
    always_comb begin
        axi_req_o         = wr_req;
        axi_req_o.arid    = rd_req.arid;
        axi_req_o.araddr  = rd_req.araddr;
        axi_req_o.arlen   = rd_req.arlen;
        axi_req_o.arsize  = rd_req.arsize;
        axi_req_o.arburst = rd_req.arburst;
        axi_req_o.arvalid = rd_req.arvalid;
        axi_req_o.rready  = rd_req.rready;
    end

endmodule

// ==== axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
    input  logic               Clk,
    input  logic               Myreset,
    input  axi_pkg::axi_req_t  axi_req_i,
    output axi_pkg::axi_resp_t axi_resp_o
);

    localparam int MEM_WORDS = 256;

    logic [31:0] mem [MEM_WORDS];
    logic [2:0]  ar_dly;
    logic [2:0]  r_dly;
    logic [2:0]  aw_dly;
    logic [2:0]  w_dly;
    logic [2:0]  b_dly;
    logic        r_pend;
    logic        b_pend;
    logic        aw_got;
    logic        w_got;
    logic [7:0]  r_idx;
    logic [7:0]  w_idx;
    logic [3:0]  r_id;
    logic [3:0]  b_id;
    logic [31:0] w_data;
    logic [3:0]  w_strb;

    // Every byte depends on the full word index
    function automatic logic [31:0] preload_word(input int idx);
        logic [7:0] i8;
        i8 = idx[7:0];
        return {i8 ^ 8'h3c, ~i8, i8 + 8'h51, i8};
    endfunction

    function automatic logic [2:0] rand_delay();
        return 3'($urandom % 5);  // 0 to 4 cycles
    endfunction

    initial begin
        axi_resp_o <= '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= preload_word(i);
        end
    end

    always @(posedge Clk) begin
        if (Myreset) begin
            axi_resp_o <= '0;
            r_pend     <= 1'b0;
            b_pend     <= 1'b0;
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            ar_dly     <= rand_delay();
            aw_dly     <= rand_delay();
            w_dly      <= rand_delay();
        end else begin
            if (axi_resp_o.arready) begin
                axi_resp_o.arready <= 1'b0;  // One-cycle ready pulse
                r_idx  <= axi_req_i.araddr[9:2];
                r_id   <= axi_req_i.arid;
                r_pend <= 1'b1;
                r_dly  <= rand_delay();
            end else if (axi_req_i.arvalid && !r_pend && !axi_resp_o.rvalid) begin
                if (ar_dly == 0) begin
                    axi_resp_o.arready <= 1'b1;
                    ar_dly <= rand_delay();
                end else begin
                    ar_dly <= ar_dly - 1'b1;
                end
            end

            if (axi_resp_o.rvalid && axi_req_i.rready) begin
                axi_resp_o.rvalid <= 1'b0;
            end else if (r_pend) begin
                if (r_dly == 0) begin
                    axi_resp_o.rvalid <= 1'b1;
                    axi_resp_o.rdata  <= mem[r_idx];
                    axi_resp_o.rid    <= r_id;
                    axi_resp_o.rresp  <= 2'b00;
                    axi_resp_o.rlast  <= 1'b1;
                    r_pend <= 1'b0;
                end else begin
                    r_dly <= r_dly - 1'b1;
                end
            end

            if (axi_resp_o.awready) begin
                axi_resp_o.awready <= 1'b0;
                aw_got <= 1'b1;
                w_idx  <= axi_req_i.awaddr[9:2];
                b_id   <= axi_req_i.awid;
            end else if (axi_req_i.awvalid && !aw_got && !b_pend && !axi_resp_o.bvalid) begin
                if (aw_dly == 0) begin
                    axi_resp_o.awready <= 1'b1;
                    aw_dly <= rand_delay();
                end else begin
                    aw_dly <= aw_dly - 1'b1;
                end
            end

            if (axi_resp_o.wready) begin
                axi_resp_o.wready <= 1'b0;
                w_got  <= 1'b1;
                w_data <= axi_req_i.wdata;
                w_strb <= axi_req_i.wstrb;
            end else if (axi_req_i.wvalid && !w_got && !b_pend && !axi_resp_o.bvalid) begin
                if (w_dly == 0) begin
                    axi_resp_o.wready <= 1'b1;
                    w_dly <= rand_delay();
                end else begin
                    w_dly <= w_dly - 1'b1;
                end
            end

            if (aw_got && w_got && !b_pend) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_strb[b]) begin
                        mem[w_idx][8*b +: 8] <= w_data[8*b +: 8];  // Byte lanes
                    end
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_pend <= 1'b1;
                b_dly  <= rand_delay();
            end

            if (axi_resp_o.bvalid && axi_req_i.bready) begin
                axi_resp_o.bvalid <= 1'b0;
            end else if (b_pend) begin
                if (b_dly == 0) begin
                    axi_resp_o.bvalid <= 1'b1;
                    axi_resp_o.bid    <= b_id;
                    axi_resp_o.bresp  <= 2'b00;
                    b_pend <= 1'b0;
                end else begin
                    b_dly <= b_dly - 1'b1;
                end
            end
        end
    end

endmodule

// ==== bridge_tb.sv ====
`timescale 1ns/1ps

module bridge_tb;

    localparam int CYCLE_LIMIT = 3000;  // About 40 transactions of 30 cycles, reset, margin

    logic                 Clk;
    logic                 Myreset;
    sram_pkg::inst_req_t  inst_req;
    sram_pkg::data_req_t  data_req;
    sram_pkg::sram_resp_t inst_resp;
    sram_pkg::sram_resp_t data_resp;
    axi_pkg::axi_req_t    axi_req;
    axi_pkg::axi_resp_t   axi_resp;

    logic [31:0] shadow [256];
    logic [3:0]  exp_id;
    logic [31:0] exp_addr;
    logic [2:0]  exp_size;
    logic [3:0]  exp_strb;
    logic [31:0] exp_wdata;
    logic        seen_grant;
    logic        busy;
    logic        ar_seen;
    logic        aw_seen;
    int          ar_total;
    int          addr_ok_total;
    int          data_ok_total;
    int          cycles;
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_clean;
    string       cur_test;

    sram_axi_bridge i_dut (
        .Clk         (Clk),
        .Myreset     (Myreset),
        .inst_req_i  (inst_req),
        .data_req_i  (data_req),
        .inst_resp_o (inst_resp),
        .data_resp_o (data_resp),
        .axi_req_o   (axi_req),
        .axi_resp_i  (axi_resp)
    );

    axi_mem_model i_mem (
        .Clk        (Clk),
        .Myreset    (Myreset),
        .axi_req_i  (axi_req),
        .axi_resp_o (axi_resp)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    function automatic logic [31:0] expected_preload(input int idx);
        logic [7:0] i8;
        i8 = idx[7:0];
        return {i8 ^ 8'h3c, ~i8, i8 + 8'h51, i8};
    endfunction

    task automatic report_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
        errors++;
        test_errs++;
    endtask

    task automatic report_fault(input string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
        test_errs++;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            tests_clean++;
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, test_errs);
        end
    endtask

    // Bus monitor
    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (inst_resp.addr_ok || data_resp.addr_ok) begin
            seen_grant <= 1'b1;
        end
        if (inst_resp.data_ok || data_resp.data_ok) begin
            busy <= 1'b0;
            data_ok_total <= data_ok_total + 1;
        end
        if (inst_resp.addr_ok || data_resp.addr_ok) begin
            busy <= 1'b1;
            addr_ok_total <= addr_ok_total + 1;
        end
        if (axi_req.arvalid && axi_resp.arready) begin
            ar_total <= ar_total + 1;
            ar_seen  <= 1'b1;
        end
        if (axi_req.rready && axi_resp.rvalid) begin
            ar_seen <= 1'b0;
        end
        if (axi_req.awvalid && axi_resp.awready) begin
            aw_seen <= 1'b1;
        end
        if (axi_req.bready && axi_resp.bvalid) begin
            aw_seen <= 1'b0;
        end
    end

    always @(posedge Clk) begin
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    a_no_early_valid: assert property (@(posedge Clk) disable iff (Myreset)
        !seen_grant |-> !(axi_req.arvalid || axi_req.awvalid || axi_req.wvalid))
        else report_fault("a valid rose before the first addr_ok");

    a_ar_addr: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.arvalid |-> axi_req.araddr == exp_addr)
        else report_value("araddr", exp_addr, $sampled(axi_req.araddr));

    a_ar_ctrl: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.arvalid |-> {axi_req.arid, axi_req.arsize, axi_req.arlen, axi_req.arburst}
            == {exp_id, exp_size, axi_pkg::LEN_SINGLE, axi_pkg::BURST_INCR})
        else report_value("ar id/size/len/burst",
            {exp_id, exp_size, axi_pkg::LEN_SINGLE, axi_pkg::BURST_INCR},
            $sampled({axi_req.arid, axi_req.arsize, axi_req.arlen, axi_req.arburst}));

    a_aw_ctrl: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.awvalid |-> {axi_req.awid, axi_req.awsize, axi_req.awaddr, axi_req.awlen,
            axi_req.awburst}
            == {axi_pkg::ID_DATA, exp_size, exp_addr, axi_pkg::LEN_SINGLE, axi_pkg::BURST_INCR})
        else report_value("aw id/size/addr/len/burst",
            {axi_pkg::ID_DATA, exp_size, exp_addr, axi_pkg::LEN_SINGLE, axi_pkg::BURST_INCR},
            $sampled({axi_req.awid, axi_req.awsize, axi_req.awaddr, axi_req.awlen,
                      axi_req.awburst}));

    a_w_strb: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.wvalid |-> axi_req.wstrb == exp_strb)
        else report_value("wstrb", exp_strb, $sampled(axi_req.wstrb));

    a_w_data: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.wvalid |-> axi_req.wdata == exp_wdata && axi_req.wlast)
        else report_value("wdata", exp_wdata, $sampled(axi_req.wdata));

    a_ar_hold: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.arvalid && !axi_resp.arready |=> axi_req.arvalid && $stable(axi_req.araddr)
            && $stable(axi_req.arid) && $stable(axi_req.arsize))
        else report_fault("AR payload changed before arready");

    a_aw_hold: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.awvalid && !axi_resp.awready |=> axi_req.awvalid
            && $stable(axi_req.awaddr) && $stable(axi_req.awsize))
        else report_fault("AW payload changed before awready");

    a_w_hold: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.wvalid && !axi_resp.wready |=> axi_req.wvalid
            && $stable(axi_req.wdata) && $stable(axi_req.wstrb))
        else report_fault("W payload changed before wready");

    a_rready_after_ar: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.rready |-> ar_seen)
        else report_fault("rready rose before the AR handshake");

    a_bready_after_aw: assert property (@(posedge Clk) disable iff (Myreset)
        axi_req.bready |-> aw_seen)
        else report_fault("bready rose before the AW handshake");

    a_single: assert property (@(posedge Clk) disable iff (Myreset)
        busy && !(inst_resp.data_ok || data_resp.data_ok)
            |-> !(inst_resp.addr_ok || data_resp.addr_ok))
        else report_fault("second addr_ok before data_ok");

    a_data_ok_owed: assert property (@(posedge Clk) disable iff (Myreset)
        (inst_resp.data_ok || data_resp.data_ok) |-> busy)
        else report_fault("data_ok without an accepted request");

    task automatic wait_addr_ok(input logic is_data);
        do @(negedge Clk); while (is_data ? !data_resp.addr_ok : !inst_resp.addr_ok);
    endtask

    task automatic wait_data_ok(input logic is_data);
        do @(negedge Clk); while (is_data ? !data_resp.data_ok : !inst_resp.data_ok);
    endtask

    task automatic check_ar_count(input int n0, input int want);
        assert (ar_total - n0 == want)
            else report_value("AR count", want, ar_total - n0);
    endtask

    task automatic fetch(input logic [31:0] addr);
        int n0;
        n0       = ar_total;
        exp_id   = axi_pkg::ID_INST;
        exp_addr = addr;
        exp_size = 3'(sram_pkg::SIZE_WORD);
        @(posedge Clk);
        inst_req.req  <= 1'b1;
        inst_req.addr <= addr;
        wait_addr_ok(1'b0);
        @(posedge Clk);
        inst_req.req <= 1'b0;
        wait_data_ok(1'b0);
        assert (inst_resp.rdata == shadow[addr[9:2]])
            else report_value("fetch rdata", shadow[addr[9:2]], inst_resp.rdata);
        check_ar_count(n0, 1);
    endtask

    task automatic data_access(input logic wr, input sram_pkg::size_e size,
                               input logic [31:0] addr, input logic [31:0] wdata);
        int n0;
        int lo;
        int nbytes;
        n0        = ar_total;
        exp_id    = axi_pkg::ID_DATA;
        exp_addr  = addr;
        exp_size  = 3'(size);
        lo        = int'(addr[1:0]);
        nbytes    = 1 << int'(size);
        for (int b = 0; b < 4; b++) begin
            exp_strb[b] = (b >= lo) && (b < lo + nbytes);  // Lanes the access covers
        end
        exp_wdata = wdata;
        @(posedge Clk);
        data_req.req   <= 1'b1;
        data_req.wr    <= wr;
        data_req.size  <= size;
        data_req.addr  <= addr;
        data_req.wdata <= wdata;
        wait_addr_ok(1'b1);
        @(posedge Clk);
        data_req.req <= 1'b0;
        wait_data_ok(1'b1);
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (exp_strb[b]) begin
                    shadow[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            check_ar_count(n0, 0);
        end else begin
            assert (data_resp.rdata == shadow[addr[9:2]])
                else report_value("data rdata", shadow[addr[9:2]], data_resp.rdata);
            check_ar_count(n0, 1);
        end
    endtask

    initial begin
        int              low_cycles;
        int              kind;
        logic [31:0]     addr;
        logic [31:0]     wdata;
        sram_pkg::size_e size;
        void'($urandom(32'h186ee5a4));
        Myreset       = 1'b1;
        inst_req      = '0;
        data_req      = '0;
        seen_grant    <= 1'b0;
        busy          <= 1'b0;
        ar_seen       <= 1'b0;
        aw_seen       <= 1'b0;
        ar_total      <= 0;
        addr_ok_total <= 0;
        data_ok_total <= 0;
        cycles        <= 0;
        errors        = 0;
        tests_run     = 0;
        tests_clean   = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = expected_preload(i);
        end

        start_test("reset_hold");
        exp_id   = axi_pkg::ID_INST;
        exp_addr = 32'h0000_0040;
        exp_size = 3'(sram_pkg::SIZE_WORD);
        repeat (10) @(posedge Clk);
        Myreset       <= 1'b0;
        inst_req.req  <= 1'b1;  // Held from the release of reset
        inst_req.addr <= 32'h0000_0040;
        @(posedge Clk);
        low_cycles = 0;
        forever begin
            @(negedge Clk);
            if (inst_resp.addr_ok) begin
                break;
            end
            low_cycles++;
            @(posedge Clk);
        end
        assert (low_cycles == sram_pkg::RESET_HOLD_CYCLES)
            else report_value("addr_ok low cycles", sram_pkg::RESET_HOLD_CYCLES, low_cycles);
        @(posedge Clk);
        inst_req.req <= 1'b0;
        wait_data_ok(1'b0);
        assert (inst_resp.rdata == shadow[16])
            else report_value("fetch rdata", shadow[16], inst_resp.rdata);
        end_test();

        start_test("inst_fetch");
        for (int k = 0; k < 5; k++) begin
            fetch(32'h0000_0100 + 32'(k * 12));
        end
        end_test();

        start_test("data_write_sizes");
        for (int off = 0; off < 4; off++) begin
            data_access(1'b1, sram_pkg::SIZE_BYTE, 32'h0000_0200 + 32'(off * 5), $urandom);
            data_access(1'b0, sram_pkg::SIZE_WORD, 32'h0000_0200 + 32'(off * 4), '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            data_access(1'b1, sram_pkg::SIZE_HALF, 32'h0000_0280 + 32'(off), $urandom);
            data_access(1'b0, sram_pkg::SIZE_WORD, 32'h0000_0280, '0);
        end
        data_access(1'b1, sram_pkg::SIZE_WORD, 32'h0000_02c0, $urandom);
        data_access(1'b0, sram_pkg::SIZE_WORD, 32'h0000_02c0, '0);
        end_test();

        start_test("priority");
        exp_id   = axi_pkg::ID_DATA;
        exp_addr = 32'h0000_0310;
        exp_size = 3'(sram_pkg::SIZE_WORD);
        @(posedge Clk);
        inst_req.req   <= 1'b1;
        inst_req.addr  <= 32'h0000_0320;
        data_req.req   <= 1'b1;
        data_req.wr    <= 1'b0;
        data_req.size  <= sram_pkg::SIZE_WORD;
        data_req.addr  <= 32'h0000_0310;
        @(negedge Clk);
        assert (data_resp.addr_ok && !inst_resp.addr_ok)
            else report_fault("data request did not win the idle cycle");
        @(posedge Clk);
        data_req.req <= 1'b0;
        do begin
            @(negedge Clk);
            assert (!inst_resp.addr_ok || data_resp.data_ok)
                else report_fault("instruction accepted before data_ok");
        end while (!data_resp.data_ok);
        assert (data_resp.rdata == shadow[196])
            else report_value("data rdata", shadow[196], data_resp.rdata);
        exp_id   = axi_pkg::ID_INST;
        exp_addr = 32'h0000_0320;
        while (!inst_resp.addr_ok) begin
            @(negedge Clk);
        end
        @(posedge Clk);
        inst_req.req <= 1'b0;
        wait_data_ok(1'b0);
        assert (inst_resp.rdata == shadow[200])
            else report_value("fetch rdata", shadow[200], inst_resp.rdata);
        end_test();

        start_test("backpressure");
        for (int k = 0; k < 14; k++) begin
            kind  = $urandom % 3;
            wdata = $urandom;
            size  = sram_pkg::size_e'($urandom % 3);
            addr  = {22'd0, 8'($urandom), 2'b00};
            if (size == sram_pkg::SIZE_BYTE) begin
                addr[1:0] = 2'($urandom);
            end else if (size == sram_pkg::SIZE_HALF) begin
                addr[1] = 1'($urandom);
            end
            if (kind == 0) begin
                fetch({addr[31:2], 2'b00});
            end else begin
                data_access(kind == 1, size, addr, wdata);
            end
        end
        repeat (2) @(posedge Clk);
        assert (addr_ok_total == data_ok_total)
            else report_value("data_ok count", addr_ok_total, data_ok_total);
        end_test();

        $display("Tests: %0d run, %0d clean, %0d with errors",
                 tests_run, tests_clean, tests_run - tests_clean);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
axi_pkg.sv
sram_pkg.sv
reset_stretch.sv
req_arbiter.sv
axi_read_ch.sv
axi_write_ch.sv
sram_axi_bridge.sv
axi_mem_model.sv
bridge_tb.sv
